/* cpuPkg.sv */
// Shared word, index, select and ALU types, opcodes, funct3 values, reset PC, sequencer states
package cpuPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;
  typedef logic [3:0]  byteSel_t;
  typedef logic [3:0]  aluOp_t;

  // ALU codes follow {bit30, funct3} of the OP encoding
  localparam aluOp_t ALU_ADD  = 4'b0000;
  localparam aluOp_t ALU_SUB  = 4'b1000;
  localparam aluOp_t ALU_SLL  = 4'b0001;
  localparam aluOp_t ALU_SLT  = 4'b0010;
  localparam aluOp_t ALU_SLTU = 4'b0011;
  localparam aluOp_t ALU_XOR  = 4'b0100;
  localparam aluOp_t ALU_SRL  = 4'b0101;
  localparam aluOp_t ALU_SRA  = 4'b1101;
  localparam aluOp_t ALU_OR   = 4'b0110;
  localparam aluOp_t ALU_AND  = 4'b0111;

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load and store widths
  localparam logic [2:0] F3_BYTE  = 3'b000;
  localparam logic [2:0] F3_BYTEU = 3'b100;
  localparam logic [2:0] F3_WORD  = 3'b010;

  localparam word_t RESET_PC = 32'h0;

  typedef enum logic [2:0] {
    FETCH,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALT
  } seqState_e;

endpackage

/* cpuIfs.sv */
// Memory request interface and instruction decode interface
`timescale 1ns/1ps

interface memReqIf import cpuPkg::*; ();

  logic     req;
  logic     we;
  word_t    addr;
  byteSel_t sel;
  word_t    wdata;
  word_t    rdata;
  logic     done;

  modport sequencer (output req, we, addr, sel, wdata, input rdata, done);
  modport requester (input req, we, addr, sel, wdata, output rdata, done);

endinterface

interface decodeIf import cpuPkg::*; ();

  aluOp_t      aluOp;
  word_t       imm;
  logic        useImm, usePc;
  logic        regWrite;
  logic        memRead, memWrite, byteAccess;
  logic        branch, jump, jumpReg, halt;
  logic [2:0]  funct3;
  logic        lui;

  modport producer (output aluOp, imm, useImm, usePc, regWrite, memRead, memWrite,
                    byteAccess, branch, jump, jumpReg, halt, funct3, lui);
  modport consumer (input aluOp, imm, useImm, usePc, regWrite, memRead, memWrite,
                    byteAccess, branch, jump, jumpReg, halt, funct3, lui);

endinterface

/* alu.sv */
// Combinational ALU with branch comparison flags
`timescale 1ns/1ps

module alu import cpuPkg::*; (
  input  aluOp_t op_i,
  input  word_t  a_i,
  input  word_t  b_i,
  output word_t  result_o,
  output logic   equal_o,
  output logic   lessThan_o,
  output logic   lessThanU_o
);

  logic    lessThan, lessThanU;
  logic [4:0] shamt;

  // Comparisons shared by SLT/SLTU and branches
  assign lessThan  = $signed(a_i) < $signed(b_i);
  assign lessThanU = a_i < b_i;
  assign shamt     = b_i[4:0];

  assign equal_o     = (a_i == b_i);
  assign lessThan_o  = lessThan;
  assign lessThanU_o = lessThanU;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {31'b0, lessThan};
      ALU_SLTU: result_o = {31'b0, lessThanU};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

/* controlUnit.sv */
// Instruction decoder producing control fields and the sign-extended immediate
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
  input word_t     instr_i,
  decodeIf.producer decode
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      immI, immS, immB, immU, immJ;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // Immediate formats
  assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
  assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                 instr_i[11:8], 1'b0};
  assign immU = {instr_i[31:12], 12'b0};
  assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                 instr_i[30:21], 1'b0};

  assign decode.funct3 = funct3;

  always_comb begin
    // Default is a no-op
    decode.aluOp      = ALU_ADD;
    decode.imm        = immI;
    decode.useImm     = 1'b0;
    decode.usePc      = 1'b0;
    decode.regWrite   = 1'b0;
    decode.memRead    = 1'b0;
    decode.memWrite   = 1'b0;
    decode.byteAccess = 1'b0;
    decode.branch     = 1'b0;
    decode.jump       = 1'b0;
    decode.jumpReg    = 1'b0;
    decode.halt       = 1'b0;
    decode.lui        = 1'b0;

    case (opcode)
      OPC_LUI: begin
        decode.imm      = immU;
        decode.regWrite = 1'b1;
        decode.lui      = 1'b1;
      end
      OPC_AUIPC: begin
        decode.imm      = immU;
        decode.usePc    = 1'b1;
        decode.useImm   = 1'b1;
        decode.regWrite = 1'b1;
      end
      OPC_JAL: begin
        decode.imm      = immJ;
        decode.jump     = 1'b1;
        decode.regWrite = 1'b1;
      end
      OPC_JALR: begin
        decode.useImm   = 1'b1;
        decode.jump     = 1'b1;
        decode.jumpReg  = 1'b1;
        decode.regWrite = 1'b1;
      end
      OPC_BRANCH: begin
        decode.imm    = immB;
        decode.branch = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == F3_WORD || funct3 == F3_BYTEU) begin
          decode.useImm     = 1'b1;
          decode.memRead    = 1'b1;
          decode.regWrite   = 1'b1;
          decode.byteAccess = (funct3 == F3_BYTEU);
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_WORD || funct3 == F3_BYTE) begin
          decode.imm        = immS;
          decode.useImm     = 1'b1;
          decode.memWrite   = 1'b1;
          decode.byteAccess = (funct3 == F3_BYTE);
        end
      end
      OPC_OPIMM: begin
        // Bit 30 only selects SRAI among immediates
        decode.aluOp    = {instr_i[30] & (funct3 == 3'b101), funct3};
        decode.useImm   = 1'b1;
        decode.regWrite = 1'b1;
      end
      OPC_OP: begin
        decode.aluOp    = {instr_i[30] & (funct3 == 3'b000 || funct3 == 3'b101), funct3};
        decode.regWrite = 1'b1;
      end
      OPC_SYSTEM: begin
        // ECALL only, everything else is ignored
        decode.halt = (instr_i[31:7] == 25'b0);
      end
      default: ;
    endcase
  end

endmodule

/* registerFile.sv */
// Register file with x0 tied to zero, two asynchronous reads and one synchronous write
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN_i,
  input  regIdx_t rs1Idx_i,
  input  regIdx_t rs2Idx_i,
  input  regIdx_t rdIdx_i,
  input  word_t   rdData_i,
  input  logic    rdWe_i,
  output word_t   rs1Data_o,
  output word_t   rs2Data_o
);

  // x1..x31 only
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rdWe_i && rdIdx_i != '0) begin
      regs[rdIdx_i] <= rdData_i;
    end
  end

  assign rs1Data_o = (rs1Idx_i == '0) ? '0 : regs[rs1Idx_i];
  assign rs2Data_o = (rs2Idx_i == '0) ? '0 : regs[rs2Idx_i];

endmodule

/* instrSequencer.sv */
// Phase FSM, program counter, operand and writeback muxes, load alignment, store lanes
`timescale 1ns/1ps

module instrSequencer import cpuPkg::*; (
  input  logic       clk,
  input  logic       rstN_i,
  memReqIf.sequencer memBus,
  decodeIf.consumer  decode,
  output word_t      instr_o,
  input  word_t      rs1Data_i,
  input  word_t      rs2Data_i,
  output regIdx_t    rdIdx_o,
  output regIdx_t    rs1Idx_o,
  output regIdx_t    rs2Idx_o,
  output word_t      rdData_o,
  output logic       rdWe_o,
  output word_t      aluA_o,
  output word_t      aluB_o,
  input  word_t      aluResult_i,
  input  logic       lessThan_i,
  input  logic       lessThanU_i,
  input  logic       equal_i,
  output logic       halt_o
);

  seqState_e  state;
  word_t      pc, instrReg, loadData, pcPlus4, nextPc, loadShifted, loadValue;
  logic [1:0] byteOff;
  logic       takeBranch;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      state <= FETCH;
      pc    <= RESET_PC;
    end else begin
      case (state)
        FETCH:     if (memBus.done) state <= EXECUTE;
        EXECUTE: begin
          if (decode.halt) state <= HALT;
          else if (decode.memRead || decode.memWrite) state <= MEMORY;
          else state <= WRITEBACK;
        end
        MEMORY:    if (memBus.done) state <= WRITEBACK;
        WRITEBACK: begin
          pc    <= nextPc;
          state <= FETCH;
        end
        default:   state <= HALT;
      endcase
    end
  end

  // Instruction and load data capture
  always_ff @(posedge clk) begin
    if (state == FETCH && memBus.done) instrReg <= memBus.rdata;
    if (state == MEMORY && memBus.done) loadData <= memBus.rdata;
  end

  assign instr_o  = instrReg;
  assign rs1Idx_o = instrReg[19:15];
  assign rs2Idx_o = instrReg[24:20];
  assign rdIdx_o  = instrReg[11:7];
  assign halt_o   = (state == HALT);

  assign aluA_o = decode.usePc ? pc : rs1Data_i;
  assign aluB_o = decode.useImm ? decode.imm : rs2Data_i;

  // Bus request, word aligned with lanes in sel
  assign byteOff       = aluResult_i[1:0];
  assign memBus.req    = (state == FETCH) || (state == MEMORY);
  assign memBus.we     = (state == MEMORY) && decode.memWrite;
  assign memBus.addr   = (state == FETCH) ? pc : {aluResult_i[31:2], 2'b00};
  assign memBus.sel    = (state == MEMORY && decode.byteAccess) ?
                         byteSel_t'(4'b0001 << byteOff) : 4'b1111;
  assign memBus.wdata  = decode.byteAccess ?
                         ({24'b0, rs2Data_i[7:0]} << {byteOff, 3'b000}) : rs2Data_i;

  // LBU picks the addressed lane and zero-extends
  assign loadShifted = loadData >> {byteOff, 3'b000};
  assign loadValue   = decode.byteAccess ? {24'b0, loadShifted[7:0]} : loadData;

  always_comb begin
    case (decode.funct3)
      F3_BEQ:  takeBranch = equal_i;
      F3_BNE:  takeBranch = !equal_i;
      F3_BLT:  takeBranch = lessThan_i;
      F3_BGE:  takeBranch = !lessThan_i;
      F3_BLTU: takeBranch = lessThanU_i;
      F3_BGEU: takeBranch = !lessThanU_i;
      default: takeBranch = 1'b0;
    endcase
  end

  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    if (decode.jumpReg) nextPc = {aluResult_i[31:1], 1'b0};
    else if (decode.jump || (decode.branch && takeBranch)) nextPc = pc + decode.imm;
    else nextPc = pcPlus4;
  end

  assign rdWe_o = (state == WRITEBACK) && decode.regWrite;

  always_comb begin
    if (decode.jump) rdData_o = pcPlus4;
    else if (decode.memRead) rdData_o = loadValue;
    else if (decode.lui) rdData_o = decode.imm;
    else rdData_o = aluResult_i;
  end

endmodule

/* requestUnit.sv */
// Bus master turning one memory request into a read or write transaction
`timescale 1ns/1ps

module requestUnit import cpuPkg::*; (
  input  logic       clk,
  input  logic       rstN_i,
  memReqIf.requester memBus,
  input  logic       busy_i,
  input  word_t      dat_i,
  output logic       read_o,
  output logic       write_o,
  output word_t      adr_o,
  output byteSel_t   sel_o,
  output word_t      dat_o
);

  // ACTIVE waits for busy to rise, WAIT for it to fall
  typedef enum logic [1:0] {
    IDLE,
    ACTIVE,
    WAIT
  } reqState_e;

  reqState_e state;
  logic      start;

  assign start = (state == IDLE) && memBus.req;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      state   <= IDLE;
      read_o  <= 1'b0;
      write_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (memBus.req) begin
            state   <= ACTIVE;
            read_o  <= !memBus.we;
            write_o <= memBus.we;
          end
        end
        ACTIVE:  if (busy_i) state <= WAIT;
        WAIT: begin
          if (!busy_i) begin
            state   <= IDLE;
            read_o  <= 1'b0;
            write_o <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, lanes and data held for the whole transaction
  always_ff @(posedge clk) begin
    if (start) begin
      adr_o <= memBus.addr;
      sel_o <= memBus.sel;
      dat_o <= memBus.wdata;
    end
  end

  assign memBus.done  = (state == WAIT) && !busy_i;
  assign memBus.rdata = dat_i;

endmodule

/* cpuCore.sv */
// Core top level wiring sequencer, decoder, ALU, register file and bus master
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
  input  logic     clk,
  input  logic     rstN_i,
  input  logic     busy_i,
  input  word_t    dat_i,
  output logic     read_o,
  output logic     write_o,
  output word_t    adr_o,
  output byteSel_t sel_o,
  output word_t    dat_o,
  output logic     halt_o
);

  memReqIf memBus ();
  decodeIf decode ();

  word_t   instr, rs1Data, rs2Data, rdData, aluA, aluB, aluResult;
  regIdx_t rdIdx, rs1Idx, rs2Idx;
  logic    rdWe, lessThan, lessThanU, equal;

  instrSequencer sequencer (
    .clk(clk), .rstN_i(rstN_i), .memBus(memBus.sequencer), .decode(decode.consumer),
    .instr_o(instr), .rs1Data_i(rs1Data), .rs2Data_i(rs2Data),
    .rdIdx_o(rdIdx), .rs1Idx_o(rs1Idx), .rs2Idx_o(rs2Idx),
    .rdData_o(rdData), .rdWe_o(rdWe), .aluA_o(aluA), .aluB_o(aluB),
    .aluResult_i(aluResult), .lessThan_i(lessThan), .lessThanU_i(lessThanU),
    .equal_i(equal), .halt_o(halt_o)
  );

  controlUnit decoder (
    .instr_i(instr), .decode(decode.producer)
  );

  // ALU operation comes straight from the decode fields
  alu aluUnit (
    .op_i(decode.aluOp), .a_i(aluA), .b_i(aluB), .result_o(aluResult),
    .equal_o(equal), .lessThan_o(lessThan), .lessThanU_o(lessThanU)
  );

  registerFile regFile (
    .clk(clk), .rstN_i(rstN_i), .rs1Idx_i(rs1Idx), .rs2Idx_i(rs2Idx),
    .rdIdx_i(rdIdx), .rdData_i(rdData), .rdWe_i(rdWe),
    .rs1Data_o(rs1Data), .rs2Data_o(rs2Data)
  );

  requestUnit busMaster (
    .clk(clk), .rstN_i(rstN_i), .memBus(memBus.requester),
    .busy_i(busy_i), .dat_i(dat_i), .read_o(read_o), .write_o(write_o),
    .adr_o(adr_o), .sel_o(sel_o), .dat_o(dat_o)
  );

endmodule

/* tb_memModel.sv */
// Behavioural bus memory with random latency, program load port and write log
`timescale 1ns/1ps

module tb_memModel import cpuPkg::*; (
  input  logic       clk,
  input  logic       rstN_i,
  input  logic       read_i,
  input  logic       write_i,
  input  word_t      adr_i,
  input  byteSel_t   sel_i,
  input  word_t      wdata_i,
  output logic       busy_o,
  output word_t      rdata_o,
  input  logic       loadEn_i,
  input  logic [5:0] loadAddr_i,
  input  word_t      loadData_i,
  output logic       wrValid_o,
  output word_t      wrAddr_o,
  output word_t      wrData_o,
  output byteSel_t   wrSel_o
);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    FINISH
  } memState_e;

  word_t       mem [64];
  memState_e   state;
  int unsigned remain;
  logic [5:0]  idx;

  assign idx = adr_i[7:2];

  always @(posedge clk) begin
    wrValid_o <= 1'b0;
    if (loadEn_i) begin
      mem[loadAddr_i] <= loadData_i;
    end
    if (!rstN_i) begin
      state   <= IDLE;
      busy_o  <= 1'b0;
      rdata_o <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (read_i || write_i) begin
            busy_o <= 1'b1;
            remain <= 1 + ($urandom % 4);
            state  <= BUSY;
          end
        end
        BUSY: begin
          if (remain > 1) begin
            remain <= remain - 1;
          end else begin
            // Data and the write land as busy falls
            busy_o <= 1'b0;
            state  <= FINISH;
            if (write_i) begin
              for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                  mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
              end
              wrValid_o <= 1'b1;
              wrAddr_o  <= adr_i;
              wrData_o  <= wdata_i;
              wrSel_o   <= sel_i;
            end else begin
              rdata_o <= mem[idx];
            end
          end
        end
        // Wait for the request to drop
        default: begin
          if (!read_i && !write_i) begin
            state <= IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* tb_cpuCore.sv */
// Testbench for cpuCore with program table, store checks, halt checks and watchdog
`timescale 1ns/1ps

module tb_cpuCore import cpuPkg::*; ();

  localparam int    CLK_PERIOD      = 4;
  localparam int    NUM_TESTS       = 5;
  localparam int    PROG_WORDS      = 16;
  localparam int    MEM_WORDS       = 64;
  localparam int    MAX_STORES      = 6;
  localparam int    WATCHDOG_CYCLES = NUM_TESTS * (PROG_WORDS * 200 + MEM_WORDS + 20);
  localparam word_t ECALL           = 32'h0000_0073;

  logic       clk, rstN, busy, read, write, halt, loadEn, wrValid;
  word_t      rdata, adr, wdata, loadData, wrAddr, wrData;
  byteSel_t   sel, wrSel;
  logic [5:0] loadAddr;

  // One row per test
  string    testName [NUM_TESTS];
  word_t    progTab  [NUM_TESTS][PROG_WORDS];
  int       progLen  [NUM_TESTS];
  word_t    expAddr  [NUM_TESTS][MAX_STORES];
  word_t    expData  [NUM_TESTS][MAX_STORES];
  byteSel_t expSel   [NUM_TESTS][MAX_STORES];
  int       expCount [NUM_TESTS];

  // Writes seen by the memory
  word_t    gotAddr[$];
  word_t    gotData[$];
  byteSel_t gotSel[$];
  int       readsAfterHalt, errors, testsFailed;

  cpuCore DUT (
    .clk(clk), .rstN_i(rstN), .busy_i(busy), .dat_i(rdata),
    .read_o(read), .write_o(write), .adr_o(adr), .sel_o(sel), .dat_o(wdata),
    .halt_o(halt)
  );

  tb_memModel memory (
    .clk(clk), .rstN_i(rstN), .read_i(read), .write_i(write), .adr_i(adr),
    .sel_i(sel), .wdata_i(wdata), .busy_o(busy), .rdata_o(rdata),
    .loadEn_i(loadEn), .loadAddr_i(loadAddr), .loadData_i(loadData),
    .wrValid_o(wrValid), .wrAddr_o(wrAddr), .wrData_o(wrData), .wrSel_o(wrSel)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (wrValid) begin
      gotAddr.push_back(wrAddr);
      gotData.push_back(wrData);
      gotSel.push_back(wrSel);
    end
    if (halt && read) begin
      readsAfterHalt++;
    end
  end

  // RV32I instruction encoders
  function automatic word_t rType(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  function automatic word_t iType(logic [6:0] opc, int rd, logic [2:0] f3, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic word_t sType(logic [2:0] f3, int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t bType(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t uType(logic [6:0] opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic word_t jType(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  function automatic word_t laneMask(byteSel_t s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  task automatic addInstr(int t, word_t w);
    progTab[t][progLen[t]] = w;
    progLen[t]++;
  endtask

  task automatic addStore(int t, word_t a, word_t d, byteSel_t s);
    expAddr[t][expCount[t]] = a;
    expData[t][expCount[t]] = d;
    expSel[t][expCount[t]]  = s;
    expCount[t]++;
  endtask

  task automatic checkWord(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAILED %t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkSel(string what, byteSel_t got, byteSel_t exp);
    if (got !== exp) begin
      $display("FAILED %t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic buildTable();
    for (int t = 0; t < NUM_TESTS; t++) begin
      progLen[t]  = 0;
      expCount[t] = 0;
    end
    // x1 = 100, x2 = -7
    testName[0] = "arithmetic";
    addInstr(0, iType(OPC_OPIMM, 1, 3'b000, 0, 100));
    addInstr(0, iType(OPC_OPIMM, 2, 3'b000, 0, -7));
    addInstr(0, rType(7'b0000000, 2, 1, 3'b000, 3));
    addInstr(0, rType(7'b0100000, 1, 2, 3'b000, 4));
    addInstr(0, rType(7'b0000000, 1, 2, 3'b010, 5));
    addInstr(0, rType(7'b0100000, 5, 2, 3'b101, 6));
    addInstr(0, rType(7'b0000000, 2, 1, 3'b100, 7));
    addInstr(0, iType(OPC_OPIMM, 8, 3'b001, 1, 4));
    for (int r = 3; r <= 8; r++) begin
      addInstr(0, sType(F3_WORD, r, 0, 32'h80 + 4 * (r - 3)));
    end
    addInstr(0, ECALL);
    addStore(0, 32'h80, 32'h0000_005D, 4'hF);
    addStore(0, 32'h84, 32'hFFFF_FF95, 4'hF);
    addStore(0, 32'h88, 32'h0000_0001, 4'hF);
    addStore(0, 32'h8C, 32'hFFFF_FFFC, 4'hF);
    addStore(0, 32'h90, 32'hFFFF_FF9D, 4'hF);
    addStore(0, 32'h94, 32'h0000_0640, 4'hF);
    // Sum 10 down to 1, then BGEU not taken and BLT taken
    testName[1] = "branches";
    addInstr(1, iType(OPC_OPIMM, 1, 3'b000, 0, 0));
    addInstr(1, iType(OPC_OPIMM, 2, 3'b000, 0, 10));
    addInstr(1, rType(7'b0000000, 2, 1, 3'b000, 1));
    addInstr(1, iType(OPC_OPIMM, 2, 3'b000, 2, -1));
    addInstr(1, bType(F3_BNE, 2, 0, -8));
    addInstr(1, sType(F3_WORD, 1, 0, 32'h80));
    addInstr(1, iType(OPC_OPIMM, 3, 3'b000, 0, 5));
    addInstr(1, bType(F3_BGEU, 0, 3, 12));
    addInstr(1, iType(OPC_OPIMM, 4, 3'b000, 0, 32'h11));
    addInstr(1, sType(F3_WORD, 4, 0, 32'h84));
    addInstr(1, bType(F3_BLT, 0, 3, 8));
    addInstr(1, iType(OPC_OPIMM, 4, 3'b000, 0, 32'h7F));
    addInstr(1, iType(OPC_OPIMM, 4, 3'b000, 4, 32'h22));
    addInstr(1, sType(F3_WORD, 4, 0, 32'h88));
    addInstr(1, ECALL);
    addStore(1, 32'h80, 32'd55, 4'hF);
    addStore(1, 32'h84, 32'h11, 4'hF);
    addStore(1, 32'h88, 32'h33, 4'hF);
    // JAL at 4 links 8, JALR at 20 links 24 and skips the word at 24
    testName[2] = "jumps";
    addInstr(2, iType(OPC_OPIMM, 1, 3'b000, 0, 7));
    addInstr(2, jType(2, 8));
    addInstr(2, iType(OPC_OPIMM, 1, 3'b000, 0, 32'h55));
    addInstr(2, sType(F3_WORD, 2, 0, 32'h80));
    addInstr(2, iType(OPC_OPIMM, 3, 3'b000, 0, 28));
    addInstr(2, iType(OPC_JALR, 4, 3'b000, 3, 0));
    addInstr(2, iType(OPC_OPIMM, 1, 3'b000, 0, 32'h66));
    addInstr(2, sType(F3_WORD, 1, 0, 32'h84));
    addInstr(2, sType(F3_WORD, 4, 0, 32'h88));
    addInstr(2, ECALL);
    addStore(2, 32'h80, 32'd8, 4'hF);
    addStore(2, 32'h84, 32'd7, 4'hF);
    addStore(2, 32'h88, 32'd24, 4'hF);
    // Byte stores to lanes 2 and 3, read back zero-extended
    testName[3] = "byte access";
    addInstr(3, iType(OPC_OPIMM, 1, 3'b000, 0, 32'hAB));
    addInstr(3, sType(F3_BYTE, 1, 0, 32'h82));
    addInstr(3, iType(OPC_OPIMM, 2, 3'b000, 0, 32'hCD));
    addInstr(3, sType(F3_BYTE, 2, 0, 32'h87));
    addInstr(3, iType(OPC_LOAD, 3, F3_BYTEU, 0, 32'h82));
    addInstr(3, sType(F3_WORD, 3, 0, 32'h88));
    addInstr(3, iType(OPC_LOAD, 4, F3_BYTEU, 0, 32'h87));
    addInstr(3, sType(F3_WORD, 4, 0, 32'h8C));
    addInstr(3, ECALL);
    addStore(3, 32'h80, 32'h00AB_0000, 4'b0100);
    addStore(3, 32'h84, 32'hCD00_0000, 4'b1000);
    addStore(3, 32'h88, 32'h0000_00AB, 4'hF);
    addStore(3, 32'h8C, 32'h0000_00CD, 4'hF);
    // AUIPC at pc 4 and pc 8
    testName[4] = "upper immediates";
    addInstr(4, uType(OPC_LUI, 1, 32'h12345));
    addInstr(4, uType(OPC_AUIPC, 2, 32'h00001));
    addInstr(4, uType(OPC_AUIPC, 3, 32'hFFFFF));
    addInstr(4, sType(F3_WORD, 1, 0, 32'h80));
    addInstr(4, sType(F3_WORD, 2, 0, 32'h84));
    addInstr(4, sType(F3_WORD, 3, 0, 32'h88));
    addInstr(4, ECALL);
    addStore(4, 32'h80, 32'h1234_5000, 4'hF);
    addStore(4, 32'h84, 32'h0000_1004, 4'hF);
    addStore(4, 32'h88, 32'hFFFF_F008, 4'hF);
  endtask

  task automatic runTest(int t);
    int errBefore;
    int n;
    errBefore = errors;
    // Core is in reset or halted while memory is loaded
    for (int i = 0; i < MEM_WORDS; i++) begin
      @(posedge clk);
      loadEn   <= 1'b1;
      loadAddr <= i[5:0];
      loadData <= (i < progLen[t]) ? progTab[t][i] : (32'hC0DE_0000 ^ word_t'(i << 2));
    end
    @(posedge clk);
    loadEn <= 1'b0;
    rstN   <= 1'b0;
    repeat (5) @(posedge clk);
    gotAddr.delete();
    gotData.delete();
    gotSel.delete();
    readsAfterHalt = 0;
    rstN <= 1'b1;
    while (!halt) @(posedge clk);
    repeat (10) @(posedge clk);
    if (!halt) begin
      $display("test %0d: halt_o fell again after ECALL", t);
      errors++;
    end
    if (readsAfterHalt != 0) begin
      $display("test %0d: %0d read cycles seen after halt", t, readsAfterHalt);
      errors++;
    end
    if (gotAddr.size() != expCount[t]) begin
      $display("test %0d: expected %0d stores but saw %0d", t, expCount[t], gotAddr.size());
      errors++;
    end
    n = (gotAddr.size() < expCount[t]) ? gotAddr.size() : expCount[t];
    for (int k = 0; k < n; k++) begin
      checkWord($sformatf("test %0d store %0d address", t, k), gotAddr[k], expAddr[t][k]);
      // Only the selected lanes carry data
      checkWord($sformatf("test %0d store %0d data", t, k),
                gotData[k] & laneMask(expSel[t][k]), expData[t][k] & laneMask(expSel[t][k]));
      checkSel($sformatf("test %0d store %0d select", t, k), gotSel[k], expSel[t][k]);
    end
    if (errors == errBefore) begin
      $display("test %0d %s: PASS", t, testName[t]);
    end else begin
      $display("test %0d %s: FAIL", t, testName[t]);
      testsFailed++;
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h9a0dd132));
    clk            = 1'b0;
    rstN           = 1'b0;
    loadEn         = 1'b0;
    loadAddr       = '0;
    loadData       = '0;
    errors         = 0;
    testsFailed    = 0;
    readsAfterHalt = 0;
    buildTable();
    for (int t = 0; t < NUM_TESTS; t++) begin
      runTest(t);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             NUM_TESTS, NUM_TESTS - testsFailed, testsFailed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the number of instruction slots
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: core never halted, sequencer stuck in %s", DUT.sequencer.state.name());
    $display("Simulation failed");
    $finish;
  end

endmodule

/* files.f */
cpuPkg.sv
cpuIfs.sv
alu.sv
controlUnit.sv
registerFile.sv
instrSequencer.sv
requestUnit.sv
cpuCore.sv
tb_memModel.sv
tb_cpuCore.sv

/* Makefile */
SRCS := $(shell cat files.f)

.PHONY: all lint clean

all: obj_dir/Vtb_cpuCore
	./obj_dir/Vtb_cpuCore | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

obj_dir/Vtb_cpuCore: files.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_cpuCore -f files.f

lint:
	verilator --lint-only --timing --top-module cpuCore -f files.f

clean:
	rm -rf obj_dir sim.log
